/* capture_pkg.sv */
package capture_pkg;

   // frame, sample word and NCO control word all share one width
   localparam int word_w = 16;

   // capture memory size in words
   localparam int ram_depth = 256;

   // one extra bit so that ram_depth itself can be represented (full)
   localparam int ptr_w = 9;

   typedef enum logic [7:0] {
      op_nop         = 8'h00,
      op_init        = 8'h01,
      op_set_freq    = 8'h02,
      op_read_sample = 8'h03
   } opcode_t;

   // host command frame, msb first on the wire
   typedef struct packed {
      logic [2:0] rsvd;
      logic       arm;
      logic       arm_update;
      logic [2:0] led;
      opcode_t    opcode;
   } cmd_t;

   // bit 15 holds the oldest sample of the word
   typedef struct packed {
      logic [word_w-1:0] data;
   } sample_t;

   typedef enum logic {
      st_cmd,
      st_freq_arg
   } ctrl_state_t;

endpackage

/* nco.sv */
`timescale 1ns/10ps

module nco
   import capture_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              clear,
   input  logic [word_w-1:0] freq_word,
   output logic              sample_bit
);

   logic [word_w-1:0] phase_acc;

   // phase restarts from zero on every arm
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         phase_acc <= '0;
      end else if (clear) begin
         phase_acc <= '0;
      end else begin
         phase_acc <= phase_acc + freq_word;
      end
   end

   // square wave is the accumulator msb, straight from the register
   assign sample_bit = phase_acc[word_w-1];

endmodule

/* sample_packer.sv */
`timescale 1ns/10ps

module sample_packer
   import capture_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    clear,
   input  logic    armed,
   input  logic    sample_bit,
   output logic    smp_valid,
   output sample_t smp_data,
   input  logic    smp_ready
);

   logic [word_w-1:0]         shift_reg;
   logic [$clog2(word_w)-1:0] bit_cnt;
   logic                      primed;
   logic                      stall;
   logic                      shift_en;

   // word waiting and nobody taking it
   assign stall    = smp_valid & ~smp_ready;
   assign shift_en = armed & primed & ~stall;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bit_cnt   <= '0;
         primed    <= 1'b0;
         smp_valid <= 1'b0;
      end else if (clear) begin
         bit_cnt   <= '0;
         primed    <= 1'b0;
         smp_valid <= 1'b0;
      end else begin
         // nco output still shows the cleared phase for one cycle after clear
         primed <= armed;
         if (smp_valid && smp_ready) begin
            smp_valid <= 1'b0;
         end
         if (shift_en) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == '1) begin
               smp_valid <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (clear) begin
         shift_reg <= '0;
      end else if (shift_en) begin
         shift_reg <= {shift_reg[word_w-2:0], sample_bit};
         if (bit_cnt == '1) begin
            smp_data.data <= {shift_reg[word_w-2:0], sample_bit};
         end
      end
   end

   // offered word must not change under back-pressure
   a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
      (smp_valid && !smp_ready && !clear) |=> (smp_valid && $stable(smp_data)));

endmodule

/* capture_ram.sv */
`timescale 1ns/10ps

module capture_ram
   import capture_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              clear,
   input  logic              armed,
   input  logic              smp_valid,
   input  sample_t           smp_data,
   output logic              smp_ready,
   output logic              rd_valid,
   output logic [word_w-1:0] rd_data,
   input  logic              rd_ready
);

   logic [word_w-1:0] mem [ram_depth];
   logic [ptr_w-1:0]  wr_ptr;
   logic [ptr_w-1:0]  rd_ptr;
   logic              wr_en;
   logic              rd_en;

   // top pointer bit set means the memory is full
   assign smp_ready = armed & ~wr_ptr[ptr_w-1];
   assign wr_en     = smp_valid & smp_ready;

   assign rd_valid = (rd_ptr < wr_ptr);
   assign rd_en    = rd_valid & rd_ready;
   assign rd_data  = mem[rd_ptr[ptr_w-2:0]];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else if (clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr[ptr_w-2:0]] <= smp_data.data;
      end
   end

   // once full, nothing moves the write pointer except a new arm
   a_full_stops: assert property (@(posedge clk) disable iff (!rst_n)
      (wr_ptr == ptr_w'(ram_depth) && !clear) |=> (wr_ptr == ptr_w'(ram_depth)));

   a_rd_behind_wr: assert property (@(posedge clk) disable iff (!rst_n)
      rd_ptr <= wr_ptr);

endmodule

/* spi_slave.sv */
`timescale 1ns/10ps

module spi_slave
   import capture_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              spi_sck,
   input  logic              spi_ss,
   input  logic              spi_mosi,
   output logic              spi_miso,
   output logic              rx_valid,
   output cmd_t              rx_data,
   input  logic              tx_valid,
   input  logic [word_w-1:0] tx_data,
   output logic              tx_ready
);

   // two sync stages plus one history stage for edge detection
   logic [2:0]                sck_sync;
   logic [2:0]                ss_sync;
   logic [1:0]                mosi_sync;
   logic                      sck_rise;
   logic                      sck_fall;
   logic                      ss_fall;
   logic                      ss_low;
   logic [$clog2(word_w)-1:0] bit_cnt;
   logic [word_w-1:0]         rx_shift;
   logic [word_w-1:0]         tx_shift;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sck_sync  <= '0;
         ss_sync   <= '1;
         mosi_sync <= '0;
      end else begin
         sck_sync  <= {sck_sync[1:0], spi_sck};
         ss_sync   <= {ss_sync[1:0], spi_ss};
         mosi_sync <= {mosi_sync[0], spi_mosi};
      end
   end

   assign sck_rise = sck_sync[1] & ~sck_sync[2];
   assign sck_fall = ~sck_sync[1] & sck_sync[2];
   assign ss_fall  = ~ss_sync[1] & ss_sync[2];
   assign ss_low   = ~ss_sync[1];

   // response is taken exactly when a new frame opens
   assign tx_ready = ss_fall;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
         tx_shift <= '0;
         spi_miso <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         if (ss_fall) begin
            bit_cnt  <= '0;
            tx_shift <= tx_valid ? tx_data : '0;
            spi_miso <= tx_valid & tx_data[word_w-1];
         end else if (!ss_low) begin
            // idle bus, a short frame is dropped with its count
            spi_miso <= 1'b0;
         end else begin
            if (sck_rise) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == '1) begin
                  rx_valid <= 1'b1;
               end
            end
            // mode 0: change miso on the falling edge
            if (sck_fall) begin
               tx_shift <= {tx_shift[word_w-2:0], 1'b0};
               spi_miso <= tx_shift[word_w-2];
            end
         end
      end
   end

   // msb first, sampled on the rising edge
   always_ff @(posedge clk) begin
      if (ss_low && sck_rise) begin
         rx_shift <= {rx_shift[word_w-2:0], mosi_sync[1]};
      end
   end

   assign rx_data = cmd_t'(rx_shift);

   a_tx_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      tx_ready |=> !tx_ready);

endmodule

/* cmd_ctrl.sv */
`timescale 1ns/10ps

module cmd_ctrl
   import capture_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              rx_valid,
   input  cmd_t              rx_data,
   output logic              tx_valid,
   output logic [word_w-1:0] tx_data,
   input  logic              tx_ready,
   input  logic              rd_valid,
   input  logic [word_w-1:0] rd_data,
   output logic              rd_ready,
   output logic              arm_pulse,
   output logic              armed,
   output logic [word_w-1:0] freq_word,
   output logic [2:0]        led
);

   ctrl_state_t state;
   cmd_t        cmd_q;
   logic        cmd_pend;

   // frame is registered first, decoded one cycle after rx_valid
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cmd_pend <= 1'b0;
      end else begin
         cmd_pend <= rx_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid) begin
         cmd_q <= rx_data;
      end
   end

   // pop the memory in the decode cycle of a read
   assign rd_ready = cmd_pend && (state == st_cmd) && (cmd_q.opcode == op_read_sample);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= st_cmd;
         tx_valid  <= 1'b0;
         tx_data   <= '0;
         arm_pulse <= 1'b0;
         armed     <= 1'b0;
         freq_word <= '0;
         led       <= '0;
      end else begin
         arm_pulse <= 1'b0;
         if (tx_ready) begin
            tx_valid <= 1'b0;
         end
         if (cmd_pend) begin
            // every frame queues a response, zero unless a read succeeds
            tx_valid <= 1'b1;
            tx_data  <= '0;
            if (state == st_freq_arg) begin
               freq_word <= cmd_q;
               state     <= st_cmd;
            end else begin
               case (cmd_q.opcode)
                  op_init: begin
                     led <= cmd_q.led;
                     if (cmd_q.arm_update) begin
                        armed     <= cmd_q.arm;
                        arm_pulse <= cmd_q.arm;
                     end
                  end
                  op_set_freq: begin
                     state <= st_freq_arg;
                  end
                  op_read_sample: begin
                     if (rd_valid) begin
                        tx_data <= rd_data;
                     end
                  end
                  default: begin
                     // nop and unknown opcodes only answer zero
                     tx_data <= '0;
                  end
               endcase
            end
         end
      end
   end

endmodule

/* capture_top.sv */
`timescale 1ns/10ps

module capture_top
   import capture_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic spi_sck,
   input  logic spi_ss,
   input  logic spi_mosi,
   output logic spi_miso,
   output logic led_r,
   output logic led_g,
   output logic led_b
);

   logic              sample_bit;
   logic              smp_valid;
   sample_t           smp_data;
   logic              smp_ready;
   logic              rd_valid;
   logic [word_w-1:0] rd_data;
   logic              rd_ready;
   logic              rx_valid;
   cmd_t              rx_data;
   logic              tx_valid;
   logic [word_w-1:0] tx_data;
   logic              tx_ready;
   logic              arm_pulse;
   logic              armed;
   logic [word_w-1:0] freq_word;
   logic [2:0]        led;

   assign led_r = led[0];
   assign led_g = led[1];
   assign led_b = led[2];

   // producer side
   nco u_nco (
      .clk(clk), .rst_n(rst_n), .clear(arm_pulse), .freq_word(freq_word),
      .sample_bit(sample_bit)
   );

   sample_packer u_packer (
      .clk(clk), .rst_n(rst_n), .clear(arm_pulse), .armed(armed), .sample_bit(sample_bit),
      .smp_valid(smp_valid), .smp_data(smp_data), .smp_ready(smp_ready)
   );

   capture_ram u_ram (
      .clk(clk), .rst_n(rst_n), .clear(arm_pulse), .armed(armed),
      .smp_valid(smp_valid), .smp_data(smp_data), .smp_ready(smp_ready),
      .rd_valid(rd_valid), .rd_data(rd_data), .rd_ready(rd_ready)
   );

   // host side
   spi_slave u_spi (
      .clk(clk), .rst_n(rst_n),
      .spi_sck(spi_sck), .spi_ss(spi_ss), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
      .rx_valid(rx_valid), .rx_data(rx_data),
      .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready)
   );

   cmd_ctrl u_ctrl (
      .clk(clk), .rst_n(rst_n), .rx_valid(rx_valid), .rx_data(rx_data),
      .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
      .rd_valid(rd_valid), .rd_data(rd_data), .rd_ready(rd_ready),
      .arm_pulse(arm_pulse), .armed(armed), .freq_word(freq_word), .led(led)
   );

endmodule

/* tb_capture_top.sv */
`timescale 1ns/10ps

module tb_capture_top
   import capture_pkg::*;
();

   localparam int capture_clks  = 4600;
   localparam int poll_limit    = 8;
   localparam int watchdog_clks = 200000;
   localparam logic [15:0] nop_frame      = 16'h0000;
   localparam logic [15:0] set_freq_frame = 16'h0002;
   localparam logic [15:0] read_frame     = 16'h0003;

   logic        clk;
   logic        rst_n;
   logic        spi_sck;
   logic        spi_ss;
   logic        spi_mosi;
   logic        spi_miso;
   logic        led_r;
   logic        led_g;
   logic        led_b;
   logic [31:0] lfsr_state;
   int          err_count;
   int          check_count;
   int          test_count;

   capture_top u_dut (
      .clk(clk), .rst_n(rst_n), .spi_sck(spi_sck), .spi_ss(spi_ss), .spi_mosi(spi_mosi),
      .spi_miso(spi_miso), .led_r(led_r), .led_g(led_g), .led_b(led_b)
   );

   always #50 clk = ~clk;

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   function automatic logic [15:0] random_bits(input int n);
      logic [15:0] val;
      val = '0;
      for (int b = 0; b < n; b++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[14:0], lfsr_state[0]};
      end
      return val;
   endfunction

   // bit 15-i of word k is the phase msb after sample 16k+i+1
   function automatic logic [15:0] exp_word(input logic [15:0] freq, input int k);
      logic [15:0] word;
      logic [31:0] step;
      logic [31:0] phase;
      word = '0;
      for (int i = 0; i < 16; i++) begin
         step = 32'(16 * k + i + 1);
         phase = step * {16'h0000, freq};
         word[15 - i] = phase[15];
      end
      return word;
   endfunction

   function automatic logic [15:0] cmd_word(input opcode_t op, input logic arm,
                                            input logic arm_update, input logic [2:0] led);
      return {3'b000, arm, arm_update, led, op};
   endfunction

   task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
                              input string msg);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_leds(input logic [2:0] exp, input string msg);
      check_value({13'h0000, led_b, led_g, led_r}, {13'h0000, exp}, msg);
   endtask

   // n rising edges, then 1 ns past the last one
   task automatic clk_step(input int n);
      for (int c = 0; c < n; c++) begin
         @(posedge clk);
      end
      #1;
   endtask

   // mode 0 host at 8 clk per bit
   // rx holds the response to the previous frame
   task automatic spi_frame(input logic [15:0] tx, output logic [15:0] rx);
      rx = '0;
      spi_ss = 1'b0;
      spi_sck = 1'b0;
      clk_step(4);
      for (int i = 15; i >= 0; i--) begin
         spi_mosi = tx[i];
         spi_sck = 1'b0;
         clk_step(4);
         rx[i] = spi_miso;
         spi_sck = 1'b1;
         clk_step(4);
      end
      spi_sck = 1'b0;
      clk_step(4);
      spi_ss = 1'b1;
      spi_mosi = 1'b0;
      clk_step(10);
   endtask

   // reads until a nonzero word shows up
   // one more read stays pending afterwards
   task automatic poll_first_word(output logic [15:0] word);
      logic [15:0] resp;
      int          frames;
      spi_frame(read_frame, resp);
      resp = '0;
      frames = 0;
      while (resp == 16'h0000 && frames < poll_limit) begin
         spi_frame(read_frame, resp);
         frames++;
      end
      if (resp == 16'h0000) begin
         err_count++;
         $display("no captured data after %0d read commands", frames);
      end
      word = resp;
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      test_count++;
      if (err_count == errs_before) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d mismatches", num, name, err_count - errs_before);
      end
   endtask

   initial begin
      for (int w = 0; w < watchdog_clks; w++) begin
         @(posedge clk);
      end
      $display("watchdog expired before the test sequence finished");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      logic [15:0] resp;
      logic [15:0] f1;
      logic [15:0] f2;
      logic [2:0]  led_val;
      int          errs;
      clk = 1'b0;
      rst_n = 1'b0;
      spi_sck = 1'b0;
      spi_ss = 1'b1;
      spi_mosi = 1'b0;
      lfsr_state = 32'ha14b_e84b;
      err_count = 0;
      check_count = 0;
      test_count = 0;
      clk_step(4);
      rst_n = 1'b1;
      clk_step(2);

      errs = err_count;
      check_leds(3'b000, "leds after reset");
      spi_frame(nop_frame, resp);
      check_value(resp, 16'h0000, "miso after reset");
      spi_frame(nop_frame, resp);
      check_value(resp, 16'h0000, "nop response");
      report_test(1, "reset and nop", errs);

      errs = err_count;
      led_val = 3'(random_bits(3));
      // bit 11 set keeps word 0 nonzero for the polling reads
      f1 = random_bits(16) | 16'h0800;
      // live nco data, arm bit given without arm_update
      spi_frame(set_freq_frame, resp);
      spi_frame(f1, resp);
      spi_frame(cmd_word(op_init, 1'b1, 1'b0, led_val), resp);
      check_leds(led_val, "leds after init without arm");
      spi_frame(read_frame, resp);
      spi_frame(nop_frame, resp);
      check_value(resp, 16'h0000, "read while not armed");
      report_test(2, "init without arm", errs);

      errs = err_count;
      led_val = 3'(random_bits(3));
      spi_frame(set_freq_frame, resp);
      spi_frame(f1, resp);
      spi_frame(cmd_word(op_init, 1'b1, 1'b1, led_val), resp);
      check_leds(led_val, "leds after init with arm");
      clk_step(capture_clks);
      poll_first_word(resp);
      check_value(resp, exp_word(f1, 0), "word 0");
      for (int k = 1; k < 8; k++) begin
         spi_frame(k < 7 ? read_frame : nop_frame, resp);
         check_value(resp, exp_word(f1, k), $sformatf("word %0d", k));
      end
      report_test(3, "capture and first 8 words", errs);

      errs = err_count;
      spi_frame(cmd_word(op_init, 1'b1, 1'b1, led_val), resp);
      spi_frame(read_frame, resp);
      check_value(resp, 16'h0000, "response to re-arm");
      spi_frame(read_frame, resp);
      check_value(resp, exp_word(f1, 0), "first read after re-arm");
      spi_frame(nop_frame, resp);
      check_value(resp, exp_word(f1, 1), "second read after re-arm");
      report_test(4, "re-arm then immediate read", errs);

      errs = err_count;
      spi_frame(cmd_word(op_init, 1'b1, 1'b1, led_val), resp);
      clk_step(capture_clks);
      spi_frame(read_frame, resp);
      check_value(resp, 16'h0000, "response to re-arm");
      for (int k = 0; k < ram_depth; k++) begin
         spi_frame(read_frame, resp);
         check_value(resp, exp_word(f1, k), $sformatf("capture word %0d", k));
      end
      spi_frame(nop_frame, resp);
      check_value(resp, 16'h0000, "read past full memory");
      report_test(5, "full capture", errs);

      errs = err_count;
      f2 = random_bits(16) | 16'h0800;
      if (f2 == f1) begin
         f2 = f2 ^ 16'h0001;
      end
      spi_frame(set_freq_frame, resp);
      spi_frame(f2, resp);
      spi_frame(cmd_word(op_init, 1'b1, 1'b1, led_val), resp);
      poll_first_word(resp);
      check_value(resp, exp_word(f2, 0), "word 0 at new frequency");
      spi_frame(nop_frame, resp);
      check_value(resp, exp_word(f2, 1), "word 1 at new frequency");
      report_test(6, "new frequency restarts phase", errs);

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* flist.f */
capture_pkg.sv
nco.sv
sample_packer.sv
capture_ram.sv
spi_slave.sv
cmd_ctrl.sv
capture_top.sv
tb_capture_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module tb_capture_top \
   -o tb_capture_top
./obj_dir/tb_capture_top | tee sim.log
if ! grep -qx "Simulation passed" sim.log; then
   echo "failure reported, see sim.log"
   exit 1
fi
echo "run complete, see sim.log"
